//--- hdl/sb_pkg.sv
`default_nettype none

package sb_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS    = 2 ** REG_ADDR_W;
  localparam int unsigned XLEN       = 32;

  // architectural register index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  // operand or result word
  typedef logic [XLEN-1:0] xlen_t;
  // functional unit code
  typedef logic [2:0] fu_t;

  // --------------------
  // functional units
  // --------------------
  // no unit, entry completes on its own one cycle after it is stored
  localparam fu_t FU_NONE  = 3'd0;
  localparam fu_t FU_ALU   = 3'd1;
  localparam fu_t FU_LOAD  = 3'd2;
  localparam fu_t FU_STORE = 3'd3;
  localparam fu_t FU_MULT  = 3'd4;

  // --------------------
  // entries
  // --------------------
  // one decoded instruction as handed over by the decoder
  typedef struct packed {
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     pc;
    xlen_t     imm;
    logic      rd_we;
  } decoded_instr_t;

  // one ring slot
  typedef struct packed {
    // slot holds an in-flight instruction
    logic           issued;
    // result has been written back
    logic           done;
    decoded_instr_t instr;
    xlen_t          result;
  } sb_entry_t;

endpackage

`default_nettype wire

//--- hdl/sb_queue_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module sb_queue_ctrl #(
  parameter int unsigned NR_ENTRIES      = 8,
  parameter int unsigned NR_COMMIT_PORTS = 2,
  localparam int unsigned TRANS_ID_W     = $clog2(NR_ENTRIES)
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       flush_i,
  input  logic                                       unresolved_branch_i,
  input  logic                                       decoded_instr_valid_i,
  input  logic                                       issue_ack_i,
  input  logic [NR_COMMIT_PORTS-1:0]                 commit_ack_i,
  output logic                                       sb_full_o,
  output logic                                       issue_instr_valid_o,
  output logic                                       decoded_instr_ack_o,
  output logic                                       issue_en_o,
  output logic [TRANS_ID_W-1:0]                      issue_ptr_o,
  output logic [NR_COMMIT_PORTS-1:0][TRANS_ID_W-1:0] commit_ptr_o
);

  // occupancy needs one bit more than the pointer to tell full from empty
  localparam int unsigned CNT_W = TRANS_ID_W + 1;

  typedef logic [TRANS_ID_W-1:0] trans_id_t;
  typedef logic [CNT_W-1:0]      cnt_t;

  trans_id_t issue_ptr_q;
  trans_id_t issue_ptr_d;
  trans_id_t commit_ptr_q;
  trans_id_t commit_ptr_d;
  cnt_t      cnt_q;
  cnt_t      cnt_d;
  cnt_t      num_commit;
  logic      full;
  logic      issue_en;

  // --------------------
  // issue gating
  // --------------------
  // ring depth is a power of two so the count msb alone marks full
  assign full      = cnt_q[CNT_W-1];
  assign sb_full_o = full;

  // an unresolved branch only holds back the valid towards issue
  assign issue_instr_valid_o = decoded_instr_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_instr_ack_o = issue_ack_i & ~full;

  // entry accepted this cycle, stored at the next edge
  assign issue_en   = decoded_instr_valid_i & decoded_instr_ack_o;
  assign issue_en_o = issue_en;

  // --------------------
  // pointer update
  // --------------------
  // acks are contiguous from port 0, so their sum is the retire count
  always_comb begin
    num_commit = '0;
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      num_commit = num_commit + cnt_t'(commit_ack_i[k]);
    end
  end

  always_comb begin
    if (flush_i) begin
      issue_ptr_d  = '0;
      commit_ptr_d = '0;
      cnt_d        = '0;
    end else begin
      issue_ptr_d  = issue_ptr_q + trans_id_t'(issue_en);
      // pointer wraps naturally modulo the ring depth
      commit_ptr_d = commit_ptr_q + num_commit[TRANS_ID_W-1:0];
      cnt_d        = cnt_q - num_commit + cnt_t'(issue_en);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      cnt_q        <= cnt_d;
    end
  end

  assign issue_ptr_o = issue_ptr_q;

  // higher commit ports look at the following slots
  for (genvar k = 0; k < NR_COMMIT_PORTS; k++) begin : gen_commit_ptr
    assign commit_ptr_o[k] = commit_ptr_q + trans_id_t'(k);
  end

endmodule

`default_nettype wire

//--- hdl/sb_entry_store.sv
`default_nettype none
`timescale 1ns/100ps

module sb_entry_store #(
  parameter int unsigned NR_ENTRIES      = 8,
  parameter int unsigned NR_WB_PORTS     = 2,
  parameter int unsigned NR_COMMIT_PORTS = 2,
  localparam int unsigned TRANS_ID_W     = $clog2(NR_ENTRIES)
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       flush_i,
  // issue write
  input  logic                                       issue_en_i,
  input  logic [TRANS_ID_W-1:0]                      issue_ptr_i,
  input  sb_pkg::decoded_instr_t                     decoded_instr_i,
  // write-back
  input  logic [NR_WB_PORTS-1:0]                     wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][TRANS_ID_W-1:0]     wb_trans_id_i,
  input  sb_pkg::xlen_t [NR_WB_PORTS-1:0]            wb_data_i,
  // commit clear
  input  logic [NR_COMMIT_PORTS-1:0]                 commit_ack_i,
  input  logic [NR_COMMIT_PORTS-1:0][TRANS_ID_W-1:0] commit_ptr_i,
  output sb_pkg::sb_entry_t [NR_ENTRIES-1:0]         entries_o
);

  sb_pkg::sb_entry_t [NR_ENTRIES-1:0] mem_q;
  sb_pkg::sb_entry_t [NR_ENTRIES-1:0] mem_d;

  // later steps override earlier ones, flush last
  always_comb begin
    mem_d = mem_q;

    // --------------------
    // issue write
    // --------------------
    // fresh slot starts without a result
    if (issue_en_i) begin
      mem_d[issue_ptr_i] = '{
        issued: 1'b1,
        done:   1'b0,
        instr:  decoded_instr_i,
        result: '0
      };
    end

    // --------------------
    // unit none
    // --------------------
    // looks at the stored copy, so completion trails the write by a cycle
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (mem_q[i].issued && (mem_q[i].instr.fu == sb_pkg::FU_NONE)) begin
        mem_d[i].done = 1'b1;
      end
    end

    // --------------------
    // write-back
    // --------------------
    // late results for slots freed by a flush are dropped here
    for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && mem_q[wb_trans_id_i[k]].issued) begin
        mem_d[wb_trans_id_i[k]].done   = 1'b1;
        mem_d[wb_trans_id_i[k]].result = wb_data_i[k];
      end
    end

    // --------------------
    // commit clear
    // --------------------
    // payload stays, only the flags drop
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      if (commit_ack_i[k]) begin
        mem_d[commit_ptr_i[k]].issued = 1'b0;
        mem_d[commit_ptr_i[k]].done   = 1'b0;
      end
    end

    // flush wipes every slot
    if (flush_i) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        mem_d[i] = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      mem_q <= mem_d;
    end
  end

  assign entries_o = mem_q;

endmodule

`default_nettype wire

//--- hdl/sb_clobber.sv
`default_nettype none
`timescale 1ns/100ps

module sb_clobber #(
  parameter int unsigned NR_ENTRIES = 8
) (
  input  sb_pkg::sb_entry_t [NR_ENTRIES-1:0] entries_i,
  output sb_pkg::fu_t [sb_pkg::NR_REGS-1:0]  rd_clobber_o
);

  sb_pkg::fu_t [sb_pkg::NR_REGS-1:0] clobber;

  // --------------------
  // writer lookup
  // --------------------
  always_comb begin
    for (int unsigned r = 0; r < sb_pkg::NR_REGS; r++) begin
      // no in-flight writer
      clobber[r] = sb_pkg::FU_NONE;
      // walk from the top so the lowest matching slot is the last to assign
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (entries_i[i].issued && entries_i[i].instr.rd_we &&
            (entries_i[i].instr.rd == sb_pkg::reg_addr_t'(r))) begin
          clobber[r] = entries_i[i].instr.fu;
        end
      end
    end
    // x0 is never written
    clobber[0] = sb_pkg::FU_NONE;
  end

  assign rd_clobber_o = clobber;

endmodule

`default_nettype wire

//--- hdl/sb_forward.sv
`default_nettype none
`timescale 1ns/100ps

module sb_forward #(
  parameter int unsigned NR_ENTRIES  = 8,
  parameter int unsigned NR_WB_PORTS = 2,
  localparam int unsigned TRANS_ID_W = $clog2(NR_ENTRIES)
) (
  input  sb_pkg::sb_entry_t [NR_ENTRIES-1:0]     entries_i,
  input  logic [NR_WB_PORTS-1:0]                 wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][TRANS_ID_W-1:0] wb_trans_id_i,
  input  sb_pkg::xlen_t [NR_WB_PORTS-1:0]        wb_data_i,
  input  sb_pkg::reg_addr_t                      rs1_i,
  input  sb_pkg::reg_addr_t                      rs2_i,
  output sb_pkg::xlen_t                          rs1_o,
  output sb_pkg::xlen_t                          rs2_o,
  output logic                                   rs1_valid_o,
  output logic                                   rs2_valid_o
);

  // forwarded operand with its valid
  typedef struct packed {
    logic          valid;
    sb_pkg::xlen_t data;
  } fwd_t;

  // index 0 is rs1, index 1 is rs2
  sb_pkg::reg_addr_t [1:0] rs;
  fwd_t [1:0]              fwd;

  assign rs = {rs2_i, rs1_i};

  // --------------------
  // priority select
  // --------------------
  // candidates are visited from lowest to highest priority,
  // so the last hit is the winner
  always_comb begin
    for (int unsigned op = 0; op < 2; op++) begin
      fwd[op] = '0;

      // completed entries, lower slot index wins
      for (int i = NR_ENTRIES - 1; i >= 0; i--) begin
        if (entries_i[i].issued && entries_i[i].done &&
            entries_i[i].instr.rd_we && (entries_i[i].instr.rd == rs[op])) begin
          fwd[op].valid = 1'b1;
          fwd[op].data  = entries_i[i].result;
        end
      end

      // write-back ports beat any stored entry, lower port wins
      for (int k = NR_WB_PORTS - 1; k >= 0; k--) begin
        if (wb_valid_i[k] && entries_i[wb_trans_id_i[k]].instr.rd_we &&
            (entries_i[wb_trans_id_i[k]].instr.rd == rs[op])) begin
          fwd[op].valid = 1'b1;
          fwd[op].data  = wb_data_i[k];
        end
      end

      // x0 reads come from the register file
      if (rs[op] == '0) begin
        fwd[op].valid = 1'b0;
      end
    end
  end

  assign rs1_o       = fwd[0].data;
  assign rs1_valid_o = fwd[0].valid;
  assign rs2_o       = fwd[1].data;
  assign rs2_valid_o = fwd[1].valid;

endmodule

`default_nettype wire

//--- hdl/sb_top.sv
`default_nettype none
`timescale 1ns/100ps

module sb_top #(
  // ring depth, power of two
  parameter int unsigned NR_ENTRIES      = 8,
  parameter int unsigned NR_WB_PORTS     = 2,
  // 1 or 2
  parameter int unsigned NR_COMMIT_PORTS = 2,
  localparam int unsigned TRANS_ID_W     = $clog2(NR_ENTRIES)
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           flush_i,
  input  logic                                           unresolved_branch_i,
  output logic                                           sb_full_o,
  // decoder side
  input  sb_pkg::decoded_instr_t                         decoded_instr_i,
  input  logic                                           decoded_instr_valid_i,
  output logic                                           decoded_instr_ack_o,
  output logic                                           issue_instr_valid_o,
  input  logic                                           issue_ack_i,
  output logic [TRANS_ID_W-1:0]                          issue_trans_id_o,
  // write-back ports
  input  logic [NR_WB_PORTS-1:0]                         wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][TRANS_ID_W-1:0]         wb_trans_id_i,
  input  sb_pkg::xlen_t [NR_WB_PORTS-1:0]                wb_data_i,
  // commit ports
  output sb_pkg::sb_entry_t [NR_COMMIT_PORTS-1:0]        commit_entry_o,
  output logic [NR_COMMIT_PORTS-1:0][TRANS_ID_W-1:0]     commit_trans_id_o,
  input  logic [NR_COMMIT_PORTS-1:0]                     commit_ack_i,
  // clobber table to issue stage
  output sb_pkg::fu_t [sb_pkg::NR_REGS-1:0]              rd_clobber_o,
  // operand read
  input  sb_pkg::reg_addr_t                              rs1_i,
  input  sb_pkg::reg_addr_t                              rs2_i,
  output sb_pkg::xlen_t                                  rs1_o,
  output sb_pkg::xlen_t                                  rs2_o,
  output logic                                           rs1_valid_o,
  output logic                                           rs2_valid_o
);

  sb_pkg::sb_entry_t [NR_ENTRIES-1:0]             entries;
  logic                                           issue_en;
  logic [TRANS_ID_W-1:0]                          issue_ptr;
  logic [NR_COMMIT_PORTS-1:0][TRANS_ID_W-1:0]     commit_ptr;

  // --------------------
  // pointer control
  // --------------------
  sb_queue_ctrl #(
    .NR_ENTRIES      (NR_ENTRIES),
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) i_queue_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .issue_ack_i           (issue_ack_i),
    .commit_ack_i          (commit_ack_i),
    .sb_full_o             (sb_full_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .issue_en_o            (issue_en),
    .issue_ptr_o           (issue_ptr),
    .commit_ptr_o          (commit_ptr)
  );

  // trans id of the next accepted entry is its slot index
  assign issue_trans_id_o = issue_ptr;

  // --------------------
  // entry registers
  // --------------------
  sb_entry_store #(
    .NR_ENTRIES      (NR_ENTRIES),
    .NR_WB_PORTS     (NR_WB_PORTS),
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) i_entry_store (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .issue_en_i      (issue_en),
    .issue_ptr_i     (issue_ptr),
    .decoded_instr_i (decoded_instr_i),
    .wb_valid_i      (wb_valid_i),
    .wb_trans_id_i   (wb_trans_id_i),
    .wb_data_i       (wb_data_i),
    .commit_ack_i    (commit_ack_i),
    .commit_ptr_i    (commit_ptr),
    .entries_o       (entries)
  );

  // commit port k shows the slot at commit pointer plus k
  for (genvar k = 0; k < NR_COMMIT_PORTS; k++) begin : gen_commit_port
    assign commit_entry_o[k]    = entries[commit_ptr[k]];
    assign commit_trans_id_o[k] = commit_ptr[k];
  end

  // --------------------
  // clobber and forwarding
  // --------------------
  sb_clobber #(
    .NR_ENTRIES (NR_ENTRIES)
  ) i_clobber (
    .entries_i    (entries),
    .rd_clobber_o (rd_clobber_o)
  );

  sb_forward #(
    .NR_ENTRIES  (NR_ENTRIES),
    .NR_WB_PORTS (NR_WB_PORTS)
  ) i_forward (
    .entries_i     (entries),
    .wb_valid_i    (wb_valid_i),
    .wb_trans_id_i (wb_trans_id_i),
    .wb_data_i     (wb_data_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .rs1_o         (rs1_o),
    .rs2_o         (rs2_o),
    .rs1_valid_o   (rs1_valid_o),
    .rs2_valid_o   (rs2_valid_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
`default_nettype none
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD = 2,
  parameter int unsigned RST_CYCLES  = 2
) (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // reset released on a rising edge, the flops still see it low there
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_ooo_scoreboard.sv
`default_nettype none
`timescale 1ns/100ps

module tb_ooo_scoreboard;

  localparam int unsigned NR_ENTRIES      = 8;
  localparam int unsigned NR_WB_PORTS     = 2;
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned TRANS_ID_W      = $clog2(NR_ENTRIES);
  // directed sequence length in cycles, with room for the commit waits
  localparam int unsigned TEST_CYCLES     = 12 * NR_ENTRIES + 40;
  localparam int unsigned TIMEOUT_CYCLES  = TEST_CYCLES + 200;

  // forwarded operand with its valid
  typedef struct packed {
    logic          valid;
    sb_pkg::xlen_t data;
  } fwd_t;

  // --------------------
  // DUT signals
  // --------------------
  logic                                       clk_i;
  logic                                       rst_ni;
  logic                                       flush_i;
  logic                                       unresolved_branch_i;
  logic                                       sb_full_o;
  sb_pkg::decoded_instr_t                     decoded_instr_i;
  logic                                       decoded_instr_valid_i;
  logic                                       decoded_instr_ack_o;
  logic                                       issue_instr_valid_o;
  logic                                       issue_ack_i;
  logic [TRANS_ID_W-1:0]                      issue_trans_id_o;
  logic [NR_WB_PORTS-1:0]                     wb_valid_i;
  logic [NR_WB_PORTS-1:0][TRANS_ID_W-1:0]     wb_trans_id_i;
  sb_pkg::xlen_t [NR_WB_PORTS-1:0]            wb_data_i;
  sb_pkg::sb_entry_t [NR_COMMIT_PORTS-1:0]    commit_entry_o;
  logic [NR_COMMIT_PORTS-1:0][TRANS_ID_W-1:0] commit_trans_id_o;
  logic [NR_COMMIT_PORTS-1:0]                 commit_ack_i;
  sb_pkg::fu_t [sb_pkg::NR_REGS-1:0]          rd_clobber_o;
  sb_pkg::reg_addr_t                          rs1_i;
  sb_pkg::reg_addr_t                          rs2_i;
  sb_pkg::xlen_t                              rs1_o;
  sb_pkg::xlen_t                              rs2_o;
  logic                                       rs1_valid_o;
  logic                                       rs2_valid_o;

  // model of the ring
  sb_pkg::sb_entry_t m_slot [NR_ENTRIES];
  int unsigned       m_issue_ptr;
  int unsigned       m_commit_ptr;
  int unsigned       m_count;
  // last write-back data per slot, checked at commit
  sb_pkg::xlen_t     wb_val [NR_ENTRIES];
  int unsigned       exp_tid = 0;
  integer            seed;
  int unsigned       checks = 0;
  int unsigned       errors = 0;
  int unsigned       cycles = 0;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  sb_top #(
    .NR_ENTRIES      (NR_ENTRIES),
    .NR_WB_PORTS     (NR_WB_PORTS),
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) u_dut (.*);

  // --------------------
  // check helpers
  // --------------------
  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_cond(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  task automatic check_clobbers_clear();
    for (int r = 0; r < sb_pkg::NR_REGS; r++) begin
      check_value($sformatf("rd_clobber_o[%0d]", r), rd_clobber_o[r], sb_pkg::FU_NONE);
    end
  endtask

  // --------------------
  // reference functions
  // --------------------
  function automatic sb_pkg::sb_entry_t expected_commit(input int unsigned k);
    return m_slot[(m_commit_ptr + k) % NR_ENTRIES];
  endfunction

  // first in-flight writer from slot 0 upwards
  function automatic sb_pkg::fu_t expected_clobber(input sb_pkg::reg_addr_t r);
    sb_pkg::fu_t fu;
    logic        found;
    fu    = sb_pkg::FU_NONE;
    found = 1'b0;
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (!found && r != '0 && m_slot[i].issued && m_slot[i].instr.rd_we &&
          m_slot[i].instr.rd == r) begin
        fu    = m_slot[i].instr.fu;
        found = 1'b1;
      end
    end
    return fu;
  endfunction

  // ports in port order first, then completed slots in index order
  function automatic fwd_t expected_forward(input sb_pkg::reg_addr_t rs);
    fwd_t f;
    f = '0;
    if (rs != '0) begin
      for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
        if (!f.valid && wb_valid_i[k] && m_slot[wb_trans_id_i[k]].instr.rd_we &&
            m_slot[wb_trans_id_i[k]].instr.rd == rs) begin
          f.valid = 1'b1;
          f.data  = wb_data_i[k];
        end
      end
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        if (!f.valid && m_slot[i].issued && m_slot[i].done && m_slot[i].instr.rd_we &&
            m_slot[i].instr.rd == rs) begin
          f.valid = 1'b1;
          f.data  = m_slot[i].result;
        end
      end
    end
    return f;
  endfunction

  function automatic sb_pkg::fu_t random_unit();
    return sb_pkg::fu_t'(1 + ($unsigned($random(seed)) % 4));
  endfunction

  // --------------------
  // model update
  // --------------------
  // issue, unit none, write-back, commit, flush, all seen at the same edge as the DUT
  always @(posedge clk_i or negedge rst_ni) begin : model_update
    sb_pkg::sb_entry_t nxt [NR_ENTRIES];
    int unsigned       n_commit;
    int unsigned       idx;
    logic              accept;
    if (!rst_ni) begin
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        m_slot[i] <= '0;
      end
      m_issue_ptr  <= 0;
      m_commit_ptr <= 0;
      m_count      <= 0;
    end else begin
      nxt    = m_slot;
      accept = decoded_instr_valid_i && issue_ack_i && (m_count < NR_ENTRIES);
      if (accept) begin
        nxt[m_issue_ptr]        = '0;
        nxt[m_issue_ptr].issued = 1'b1;
        nxt[m_issue_ptr].instr  = decoded_instr_i;
      end
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        if (m_slot[i].issued && m_slot[i].instr.fu == sb_pkg::FU_NONE) begin
          nxt[i].done = 1'b1;
        end
      end
      for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
        if (wb_valid_i[k] && m_slot[wb_trans_id_i[k]].issued) begin
          nxt[wb_trans_id_i[k]].done   = 1'b1;
          nxt[wb_trans_id_i[k]].result = wb_data_i[k];
        end
      end
      n_commit = 0;
      for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
        if (commit_ack_i[k]) begin
          idx             = (m_commit_ptr + k) % NR_ENTRIES;
          nxt[idx].issued = 1'b0;
          nxt[idx].done   = 1'b0;
          n_commit++;
        end
      end
      if (flush_i) begin
        for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
          nxt[i] = '0;
        end
        m_issue_ptr  <= 0;
        m_commit_ptr <= 0;
        m_count      <= 0;
      end else begin
        m_issue_ptr  <= (m_issue_ptr + accept) % NR_ENTRIES;
        m_commit_ptr <= (m_commit_ptr + n_commit) % NR_ENTRIES;
        m_count      <= m_count + accept - n_commit;
      end
      m_slot <= nxt;
    end
  end

  // --------------------
  // compare on the falling edge
  // --------------------
  always @(negedge clk_i) begin : compare_outputs
    fwd_t f1;
    fwd_t f2;
    if (rst_ni) begin
      check_value("sb_full_o", sb_full_o, m_count == NR_ENTRIES);
      check_value("issue_instr_valid_o", issue_instr_valid_o,
                  decoded_instr_valid_i && !unresolved_branch_i && m_count < NR_ENTRIES);
      check_value("decoded_instr_ack_o", decoded_instr_ack_o,
                  issue_ack_i && m_count < NR_ENTRIES);
      check_value("issue_trans_id_o", issue_trans_id_o, m_issue_ptr);
      for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
        check_value($sformatf("commit_entry_o[%0d]", k), commit_entry_o[k], expected_commit(k));
        check_value($sformatf("commit_trans_id_o[%0d]", k), commit_trans_id_o[k],
                    (m_commit_ptr + k) % NR_ENTRIES);
      end
      for (int r = 0; r < sb_pkg::NR_REGS; r++) begin
        check_value($sformatf("rd_clobber_o[%0d]", r), rd_clobber_o[r],
                    expected_clobber(sb_pkg::reg_addr_t'(r)));
      end
      f1 = expected_forward(rs1_i);
      f2 = expected_forward(rs2_i);
      check_value("rs1_valid_o", rs1_valid_o, f1.valid);
      check_value("rs2_valid_o", rs2_valid_o, f2.valid);
      // data only matters when valid
      if (f1.valid) begin
        check_value("rs1_o", rs1_o, f1.data);
      end
      if (f2.valid) begin
        check_value("rs2_o", rs2_o, f2.data);
      end
    end
  end

  // --------------------
  // stimulus tasks
  // --------------------
  // idle strobes and fresh operand addresses, callers override after this
  task automatic next_cycle();
    @(posedge clk_i);
    flush_i               <= 1'b0;
    unresolved_branch_i   <= 1'b0;
    decoded_instr_valid_i <= 1'b0;
    issue_ack_i           <= 1'b0;
    wb_valid_i            <= '0;
    commit_ack_i          <= '0;
    rs1_i                 <= sb_pkg::reg_addr_t'($random(seed) & 7);
    rs2_i                 <= sb_pkg::reg_addr_t'($random(seed) & 7);
  endtask

  // holds the instruction until the ack, returns the trans id it got
  task automatic issue_instr(input sb_pkg::fu_t fu, input sb_pkg::reg_addr_t rd,
                             input logic rd_we, output int unsigned tid);
    sb_pkg::decoded_instr_t instr;
    instr.fu    = fu;
    instr.rd    = rd;
    instr.pc    = $random(seed);
    instr.imm   = $random(seed);
    instr.rd_we = rd_we;
    do begin
      next_cycle();
      decoded_instr_i       <= instr;
      decoded_instr_valid_i <= 1'b1;
      issue_ack_i           <= 1'b1;
      @(negedge clk_i);
    end while (!decoded_instr_ack_o);
    tid = issue_trans_id_o;
  endtask

  task automatic write_back(input logic [1:0] valid, input int unsigned id0,
                            input int unsigned id1, input sb_pkg::reg_addr_t r1,
                            input sb_pkg::reg_addr_t r2);
    sb_pkg::xlen_t d0;
    sb_pkg::xlen_t d1;
    d0 = $random(seed);
    d1 = $random(seed);
    next_cycle();
    wb_valid_i       <= valid;
    wb_trans_id_i[0] <= TRANS_ID_W'(id0);
    wb_trans_id_i[1] <= TRANS_ID_W'(id1);
    wb_data_i[0]     <= d0;
    wb_data_i[1]     <= d1;
    rs1_i            <= r1;
    rs2_i            <= r2;
    if (valid[1]) begin
      wb_val[id1] = d1;
    end
    if (valid[0]) begin
      wb_val[id0] = d0;
    end
  endtask

  // waits for a done head, acks it and the next slot too when that one is done
  task automatic commit_ready(output int unsigned n);
    logic both;
    next_cycle();
    @(negedge clk_i);
    while (!(commit_entry_o[0].issued && commit_entry_o[0].done)) begin
      next_cycle();
      @(negedge clk_i);
    end
    both = commit_entry_o[1].issued && commit_entry_o[1].done;
    check_value("commit_trans_id_o[0]", commit_trans_id_o[0], exp_tid);
    check_value("commit_entry_o[0].result", commit_entry_o[0].result, wb_val[exp_tid]);
    if (both) begin
      check_value("commit_trans_id_o[1]", commit_trans_id_o[1], (exp_tid + 1) % NR_ENTRIES);
      check_value("commit_entry_o[1].result", commit_entry_o[1].result,
                  wb_val[(exp_tid + 1) % NR_ENTRIES]);
    end
    n = both ? 2 : 1;
    next_cycle();
    commit_ack_i <= {both, 1'b1};
    exp_tid      = (exp_tid + n) % NR_ENTRIES;
  endtask

  // --------------------
  // directed sequence
  // --------------------
  initial begin : stimulus
    int unsigned tid;
    int unsigned n;
    int unsigned left;
    sb_pkg::fu_t fu;
    seed                  = 32'hc2bcc059;
    flush_i               = 1'b0;
    unresolved_branch_i   = 1'b0;
    decoded_instr_i       = '0;
    decoded_instr_valid_i = 1'b0;
    issue_ack_i           = 1'b0;
    wb_valid_i            = '0;
    wb_trans_id_i         = '0;
    wb_data_i             = '0;
    commit_ack_i          = '0;
    rs1_i                 = '0;
    rs2_i                 = '0;
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      wb_val[i] = '0;
    end
    wait (rst_ni === 1'b1);
    @(negedge clk_i);

    // unresolved branch holds back issue valid
    next_cycle();
    decoded_instr_valid_i <= 1'b1;
    unresolved_branch_i   <= 1'b1;
    @(negedge clk_i);
    check_value("issue_instr_valid_o", issue_instr_valid_o, 1'b0);
    next_cycle();
    decoded_instr_valid_i <= 1'b1;
    @(negedge clk_i);
    check_value("issue_instr_valid_o", issue_instr_valid_o, 1'b1);

    // fill the ring, slots 1 and 6 without a unit, rd repeats every 4 slots
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      fu = (i == 1 || i == 6) ? sb_pkg::FU_NONE : random_unit();
      issue_instr(fu, sb_pkg::reg_addr_t'(i % 4), i != 4, tid);
      check_value("issue_trans_id_o", tid, i);
    end
    next_cycle();
    decoded_instr_valid_i <= 1'b1;
    issue_ack_i           <= 1'b1;
    @(negedge clk_i);
    check_value("sb_full_o", sb_full_o, 1'b1);
    check_value("decoded_instr_ack_o", decoded_instr_ack_o, 1'b0);
    check_value("issue_instr_valid_o", issue_instr_valid_o, 1'b0);

    // out of order write-back with forwarding corner cases
    // port beats the done x1 writer in slot 1
    write_back(2'b01, 5, 0, 5'd1, 5'd1);
    // slots 7 and 3 both write x3, port 0 wins
    write_back(2'b11, 7, 3, 5'd3, 5'd1);
    // x0 never forwards
    write_back(2'b11, 2, 0, 5'd2, 5'd0);
    write_back(2'b10, 0, 4, 5'd0, 5'd3);

    // dual commit frees two slots
    commit_ready(n);
    check_cond(n == 2, "both commit ports should be acked once the head pair is done");
    next_cycle();
    @(negedge clk_i);
    check_value("sb_full_o", sb_full_o, 1'b0);
    check_value("commit_trans_id_o[0]", commit_trans_id_o[0], 2);
    // issue wraps around to slot 0
    issue_instr(random_unit(), sb_pkg::reg_addr_t'($random(seed)), 1'b1, tid);
    check_value("issue_trans_id_o", tid, 0);
    write_back(2'b01, 0, 0, sb_pkg::reg_addr_t'($random(seed)), 5'd3);

    // drain in order
    left = NR_ENTRIES - 1;
    while (left > 0) begin
      commit_ready(n);
      left = left - n;
    end
    next_cycle();
    @(negedge clk_i);
    check_clobbers_clear();

    // flush with issue and write-back in the same cycle
    // slots 1 to 3 write x5 to x7, slot 1 completes without a unit
    for (int unsigned i = 0; i < 3; i++) begin
      fu = (i == 0) ? sb_pkg::FU_NONE : random_unit();
      issue_instr(fu, sb_pkg::reg_addr_t'(5 + i), 1'b1, tid);
    end
    next_cycle();
    flush_i               <= 1'b1;
    decoded_instr_valid_i <= 1'b1;
    issue_ack_i           <= 1'b1;
    wb_valid_i            <= 2'b01;
    wb_trans_id_i[0]      <= TRANS_ID_W'(2);
    next_cycle();
    // read the registers of the flushed writers
    rs1_i <= 5'd5;
    rs2_i <= 5'd6;
    @(negedge clk_i);
    check_clobbers_clear();
    check_value("rs1_valid_o", rs1_valid_o, 1'b0);
    check_value("rs2_valid_o", rs2_valid_o, 1'b0);
    check_value("issue_trans_id_o", issue_trans_id_o, 0);
    issue_instr(sb_pkg::FU_ALU, 5'd9, 1'b1, tid);
    check_value("issue_trans_id_o", tid, 0);
    repeat (2) next_cycle();

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog
  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the DUT never gave the expected handshake", cycles);
      $display("checks: %0d  errors: %0d", checks, errors);
      $display("Test failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- ooo_scoreboard.f
hdl/sb_pkg.sv
hdl/sb_queue_ctrl.sv
hdl/sb_entry_store.sv
hdl/sb_clobber.sv
hdl/sb_forward.sv
hdl/sb_top.sv
testbench/tb_clk_gen.sv
testbench/tb_ooo_scoreboard.sv

//--- run_sim.sh
#!/bin/sh
# build and run the scoreboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f ooo_scoreboard.f \
  --top-module tb_ooo_scoreboard \
  -o sim_ooo_scoreboard
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_ooo_scoreboard > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
